// File: build.f
design/rd_pkg.sv
design/read_commands.sv
design/read_mutex.sv
design/read_regfile.sv
design/read_effective_address.sv
design/read_stage.sv
design/rd_top.sv
dv/rd_assertions.sv
dv/rd_tb.sv

// File: Bender.yml
package:
  name: rd_stage

sources:
  - design/rd_pkg.sv
  - design/read_commands.sv
  - design/read_mutex.sv
  - design/read_regfile.sv
  - design/read_effective_address.sv
  - design/read_stage.sv
  - design/rd_top.sv
  - target: test
    files:
      - dv/rd_assertions.sv
      - dv/rd_tb.sv

// File: dv/rd_tb.sv
// Testbench for the read stage.
// Plays decoder, memory, execute and writeback around rd_top.
// Operand values, read addresses and lock order are checked against a
// register and busy model; protocol timing lives in rd_assertions.
// Stimulus and all random delays come from one xorshift generator.
`timescale 1ns/1ps
`default_nettype none

module rd_tb;
    import rd_pkg::*;

    localparam word_t DATA_MASK        = 32'h5a5a_a5a5;
    localparam int    CYCLES_PER_INSTR = 200;
    localparam int    RESET_CYCLES     = 5;
    localparam int    RANDOM_INSTRS    = 24;

    typedef struct packed {
        reg_idx_t    idx;
        word_t       value;
        logic [31:0] due;
    } wb_entry_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    rd_instr_t in_instr;
    logic      in_ready;
    logic      read_req;
    mem_req_t  read_addr;
    logic      read_done;
    word_t     read_data;
    logic      exe_valid;
    exe_op_t   exe_op;
    logic      wb_valid;
    reg_idx_t  wb_reg;
    word_t     wb_value;

    rd_instr_t   prog[$];
    int          gap_q[$];
    wb_entry_t   wb_q[$];
    word_t       reg_model [NUM_REGS];
    reg_mask_t   busy_model;
    rd_instr_t   cur_instr;
    int          read_count;
    int          exe_count;
    int          mem_wait;
    word_t       mem_addr;
    logic [31:0] rng_state;
    int          cycle_count;
    int          cycle_limit;

    rd_top dut_i (.*);

    bind rd_top rd_assertions checks_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .read_req  (read_req),
        .read_done (read_done),
        .exe_valid (exe_valid),
        .lock_wait (lock_wait),
        .need_read (ctrl.need_read),
        .ea_start  (ea_start)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic add_instr(input cmd_t cmd, input reg_idx_t r, input reg_idx_t rm,
                             input logic rep, input word_t imm, input int gap);
        rd_instr_t ins;
        ins = '{cmd: cmd, reg_field: r, rm_field: rm, rep: rep, imm: imm};
        prog.push_back(ins);
        gap_q.push_back(gap);
    endtask

    // --------------------------------------------------
    // reference rules
    // --------------------------------------------------
    function automatic reg_mask_t needed_regs(input rd_instr_t ins);
        reg_mask_t m;
        m = 8'b1 << ins.reg_field;
        if (ins.cmd == CMD_MOV_RR || ins.cmd == CMD_LOAD) begin
            m = m | (8'b1 << ins.rm_field);
        end else if (ins.cmd == CMD_LODS) begin
            m = (8'b1 << REG_EAX) | (8'b1 << REG_ESI) | (ins.rep ? 8'b1 << REG_ECX : 8'b0);
        end
        return m;
    endfunction

    function automatic reg_idx_t dest_of(input rd_instr_t ins);
        return (ins.cmd == CMD_LODS) ? REG_EAX : ins.reg_field;
    endfunction

    function automatic logic string_skipped(input rd_instr_t ins);
        return (ins.cmd == CMD_LODS) && ins.rep && (reg_model[REG_ECX] == '0);
    endfunction

    function automatic word_t expected_addr(input rd_instr_t ins);
        if (ins.cmd == CMD_LODS) begin
            return reg_model[REG_ESI];
        end
        return reg_model[ins.rm_field] + ins.imm;
    endfunction

    task automatic check_exe(input exe_op_t op);
        reg_idx_t  dst;
        word_t     exp_src;
        word_t     result;
        int        exp_reads;
        wb_entry_t entry;
        if ((busy_model & needed_regs(cur_instr)) != '0) begin
            stop_with_failure("exe_valid reached while a needed register awaits writeback");
        end
        dst       = dest_of(cur_instr);
        exp_reads = 0;
        case (cur_instr.cmd)
            CMD_MOV_RR:  exp_src = reg_model[cur_instr.rm_field];
            CMD_ADD_IMM: exp_src = cur_instr.imm;
            default: begin
                exp_src   = string_skipped(cur_instr) ? '0 : expected_addr(cur_instr) ^ DATA_MASK;
                exp_reads = string_skipped(cur_instr) ? 0 : 1;
            end
        endcase
        check_value("exe_op.cmd", op.cmd, cur_instr.cmd);
        check_value("exe_op.dst_reg", op.dst_reg, dst);
        check_value("exe_op.dst_value", op.dst_value, reg_model[dst]);
        check_value("exe_op.src_value", op.src_value, exp_src);
        check_value("exe_op.skip", op.skip, string_skipped(cur_instr));
        check_value("read_req count", read_count, exp_reads);
        // skipped string op leaves eax as it was
        if (string_skipped(cur_instr)) begin
            result = reg_model[dst];
        end else if (cur_instr.cmd == CMD_ADD_IMM) begin
            result = reg_model[dst] + cur_instr.imm;
        end else begin
            result = exp_src;
        end
        entry.idx   = dst;
        entry.value = result;
        entry.due   = cycle_count + next_random() % 6;
        // one writeback per cycle, in order
        if (wb_q.size() > 0 && entry.due <= wb_q[$].due) begin
            entry.due = wb_q[$].due + 1;
        end
        wb_q.push_back(entry);
        exe_count++;
    endtask

    task automatic build_program();
        cmd_t cmds [4];
        cmds = '{CMD_MOV_RR, CMD_LOAD, CMD_ADD_IMM, CMD_LODS};
        add_instr(CMD_ADD_IMM, REG_EAX, REG_EAX, 1'b0, 32'h0000_1000, 0);
        add_instr(CMD_ADD_IMM, REG_ESI, REG_ESI, 1'b0, 32'h2000_0040, 2);
        add_instr(CMD_MOV_RR, REG_EBX, REG_EAX, 1'b0, 32'h0, 0);
        add_instr(CMD_LOAD, REG_EDX, REG_EBX, 1'b0, 32'h0000_0024, 0);
        add_instr(CMD_ADD_IMM, REG_EDX, REG_EDX, 1'b0, 32'h0000_0005, 1);
        // rep with ecx still zero
        add_instr(CMD_LODS, REG_EAX, REG_EAX, 1'b1, 32'h0, 0);
        add_instr(CMD_LODS, REG_EAX, REG_EAX, 1'b0, 32'h0, 0);
        add_instr(CMD_ADD_IMM, REG_ECX, REG_ECX, 1'b0, 32'h0000_0003, 0);
        add_instr(CMD_LODS, REG_EAX, REG_EAX, 1'b1, 32'h0, 2);
        add_instr(CMD_MOV_RR, REG_EDI, REG_EDX, 1'b0, 32'h0, 0);
        add_instr(CMD_LOAD, REG_EAX, REG_ESI, 1'b0, 32'hffff_fff0, 3);
        for (int i = 0; i < RANDOM_INSTRS; i++) begin
            add_instr(cmds[next_random() % 4], reg_idx_t'(next_random()),
                      reg_idx_t'(next_random()), next_random() % 2,
                      next_random(), next_random() % 3);
        end
    endtask

    // --------------------------------------------------
    // monitor, memory and execute/writeback models
    // --------------------------------------------------
    always begin
        @(posedge clk);
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_with_failure("timeout: the run did not finish within the cycle limit");
        end
        if (dut_i.checks_i.fail_count != 0) begin
            stop_with_failure("a protocol assertion failed");
        end
        if (rst_n) begin
            if (in_valid && in_ready) begin
                cur_instr  = in_instr;
                read_count = 0;
            end
            if (read_req) begin
                if (mem_wait != 0) begin
                    stop_with_failure("read_req issued while a read was still outstanding");
                end
                check_value("read_addr", read_addr.address, expected_addr(cur_instr));
                read_count++;
                mem_addr = read_addr.address;
                mem_wait = 1 + int'(next_random() % 4);
            end
            if (exe_valid) begin
                check_exe(exe_op);
            end
            // writeback clears first, then the issue sets
            if (wb_valid) begin
                reg_model[wb_reg]  = wb_value;
                busy_model[wb_reg] = 1'b0;
            end
            if (exe_valid) begin
                busy_model[dest_of(cur_instr)] = 1'b1;
            end
        end
        #1;
        read_done = 1'b0;
        if (mem_wait > 0) begin
            mem_wait--;
            if (mem_wait == 0) begin
                read_done = 1'b1;
                read_data = mem_addr ^ DATA_MASK;
            end
        end
        wb_valid = 1'b0;
        if (wb_q.size() > 0 && wb_q[0].due <= cycle_count) begin
            wb_valid = 1'b1;
            wb_reg   = wb_q[0].idx;
            wb_value = wb_q[0].value;
            void'(wb_q.pop_front());
        end
    end

    // --------------------------------------------------
    // instruction driver
    // --------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        read_done   = 1'b0;
        read_data   = '0;
        wb_valid    = 1'b0;
        wb_reg      = '0;
        wb_value    = '0;
        busy_model  = '0;
        read_count  = 0;
        exe_count   = 0;
        mem_wait    = 0;
        mem_addr    = '0;
        cur_instr   = '0;
        cycle_count = 0;
        rng_state   = 32'hf09b_ffef;
        for (int i = 0; i < NUM_REGS; i++) begin
            reg_model[i] = '0;
        end
        build_program();
        cycle_limit = CYCLES_PER_INSTR * prog.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_value("in_ready", in_ready, 1'b1);
        for (int i = 0; i < prog.size(); i++) begin
            in_valid = 1'b1;
            in_instr = prog[i];
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            #1;
            in_valid = 1'b0;
            repeat (gap_q[i]) begin
                @(posedge clk);
                #1;
            end
        end
        while (exe_count < prog.size() || wb_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        // every writeback has landed, so the scoreboard must be empty
        if (dut_i.checks_i.fail_count == 0 && dut_i.mutex_i.busy_bit == '0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_with_failure("run ended with a failed assertion or a register still busy");
        end
    end

endmodule

`default_nettype wire

// File: dv/rd_assertions.sv
// Protocol and timing checks, bound into rd_top.
// Assumes one instruction in flight and one read_done per read_req.
// Each failure bumps fail_count, which the testbench watches.
`timescale 1ns/1ps
`default_nettype none

module rd_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_ready,
    input logic read_req,
    input logic read_done,
    input logic exe_valid,
    input logic lock_wait,
    input logic need_read,
    input logic ea_start
);

    int unsigned fail_count = 0;
    logic        held;
    logic        started;

    // instruction held between accept and hand-off
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held    <= 1'b0;
            started <= 1'b0;
        end else if (in_valid && in_ready) begin
            held    <= 1'b1;
            started <= 1'b1;
        end else if (exe_valid) begin
            held <= 1'b0;
        end
    end

    // --------------------------------------------------
    // strobes and handshake
    // --------------------------------------------------
    reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (in_ready && !read_req && !exe_valid))
        else begin
            fail_count++;
            $error("stage active before the first instruction");
        end

    read_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        read_req |=> !read_req)
        else begin
            fail_count++;
            $error("read_req high two cycles in a row");
        end

    exe_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        exe_valid |=> !exe_valid)
        else begin
            fail_count++;
            $error("exe_valid high two cycles in a row");
        end

    ready_while_held: assert property (@(posedge clk) disable iff (!rst_n)
        held |-> !in_ready)
        else begin
            fail_count++;
            $error("in_ready high while an instruction is held");
        end

    ready_after_exe: assert property (@(posedge clk) disable iff (!rst_n)
        exe_valid |=> in_ready)
        else begin
            fail_count++;
            $error("in_ready did not return after exe_valid");
        end

    // --------------------------------------------------
    // pipeline timing
    // --------------------------------------------------
    fast_path: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && in_ready) ##1 (!lock_wait && !need_read) |=> exe_valid)
        else begin
            fail_count++;
            $error("exe_valid not 2 cycles after accept with free registers");
        end

    read_after_address: assert property (@(posedge clk) disable iff (!rst_n)
        ea_start |-> ##2 read_req)
        else begin
            fail_count++;
            $error("read_req not issued after one address cycle");
        end

    exe_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        read_done |=> exe_valid)
        else begin
            fail_count++;
            $error("exe_valid not 1 cycle after read_done");
        end

endmodule

`default_nettype wire

// File: design/rd_top.sv
// Read stage top level.
// One instruction in flight; the decoder, execute and writeback stages
// sit outside and talk through the ports below.
`timescale 1ns/1ps
`default_nettype none

module rd_top (
    input  logic              clk,
    input  logic              rst_n,
    // decoder side
    input  logic              in_valid,
    input  rd_pkg::rd_instr_t in_instr,
    output logic              in_ready,
    // memory
    output logic              read_req,
    output rd_pkg::mem_req_t  read_addr,
    input  logic              read_done,
    input  rd_pkg::word_t     read_data,
    // execute
    output logic              exe_valid,
    output rd_pkg::exe_op_t   exe_op,
    // writeback
    input  logic              wb_valid,
    input  rd_pkg::reg_idx_t  wb_reg,
    input  rd_pkg::word_t     wb_value
);
    import rd_pkg::*;

    rd_instr_t instr_hold;
    rd_ctrl_t  ctrl;
    logic      lock_wait;
    logic      issue;
    word_t     rm_value;
    word_t     reg_value;
    word_t     ecx_value;
    word_t     esi_value;
    logic      ea_start;
    word_t     ea_base;
    word_t     ea_disp;
    logic      ea_ready;
    mem_req_t  ea;

    read_stage stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_ready   (in_ready),
        .ctrl       (ctrl),
        .instr_hold (instr_hold),
        .lock_wait  (lock_wait),
        .issue      (issue),
        .rm_value   (rm_value),
        .reg_value  (reg_value),
        .esi_value  (esi_value),
        .ea_start   (ea_start),
        .ea_base    (ea_base),
        .ea_disp    (ea_disp),
        .ea_ready   (ea_ready),
        .ea         (ea),
        .read_req   (read_req),
        .read_addr  (read_addr),
        .read_done  (read_done),
        .read_data  (read_data),
        .exe_valid  (exe_valid),
        .exe_op     (exe_op)
    );

    read_commands commands_i (
        .instr     (instr_hold),
        .ecx_value (ecx_value),
        .ctrl      (ctrl)
    );

    read_mutex mutex_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_mask  (ctrl.req_mask),
        .issue     (issue),
        .issue_reg (ctrl.dst_reg),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .lock_wait (lock_wait)
    );

    // destination read port follows the decoded dst, eax for string loads
    read_regfile regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_value  (wb_value),
        .rm_idx    (instr_hold.rm_field),
        .reg_idx   (ctrl.dst_reg),
        .rm_value  (rm_value),
        .reg_value (reg_value),
        .ecx_value (ecx_value),
        .esi_value (esi_value)
    );

    read_effective_address ea_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (ea_start),
        .base     (ea_base),
        .disp     (ea_disp),
        .ea       (ea),
        .ea_ready (ea_ready)
    );

endmodule

`default_nettype wire

// File: design/read_stage.sv
// Read stage sequencer.
// Holds one instruction at a time; in_ready only in ST_IDLE.
// Memory and execute ports are strobes with no back-pressure, and
// exactly one read_done is expected per read_req.
// Register values are sampled live in ST_EXE, which is safe because the
// lock wait has already cleared every register the op touches.
`timescale 1ns/1ps
`default_nettype none

module read_stage (
    input  logic              clk,
    input  logic              rst_n,
    // instruction input
    input  logic              in_valid,
    input  rd_pkg::rd_instr_t in_instr,
    output logic              in_ready,
    // decode
    input  rd_pkg::rd_ctrl_t  ctrl,
    output rd_pkg::rd_instr_t instr_hold,
    // scoreboard
    input  logic              lock_wait,
    output logic              issue,
    // register values
    input  rd_pkg::word_t     rm_value,
    input  rd_pkg::word_t     reg_value,
    input  rd_pkg::word_t     esi_value,
    // address unit
    output logic              ea_start,
    output rd_pkg::word_t     ea_base,
    output rd_pkg::word_t     ea_disp,
    input  logic              ea_ready,
    input  rd_pkg::mem_req_t  ea,
    // memory
    output logic              read_req,
    output rd_pkg::mem_req_t  read_addr,
    input  logic              read_done,
    input  rd_pkg::word_t     read_data,
    // execute
    output logic              exe_valid,
    output rd_pkg::exe_op_t   exe_op
);
    import rd_pkg::*;

    rd_state_t state_q;
    rd_state_t state_d;
    logic      read_req_q;
    word_t     read_data_q;
    word_t     src_value;

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_comb begin
        state_d  = state_q;
        ea_start = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (in_valid) begin
                    state_d = ST_LOCK;
                end
            end
            ST_LOCK: begin
                if (!lock_wait) begin
                    if (ctrl.need_read) begin
                        ea_start = 1'b1;
                        state_d  = ST_ADDRESS;
                    end else begin
                        state_d = ST_EXE;
                    end
                end
            end
            ST_ADDRESS: begin
                if (ea_ready) begin
                    state_d = ST_READ;
                end
            end
            ST_READ: begin
                if (read_done) begin
                    state_d = ST_EXE;
                end
            end
            ST_EXE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            read_req_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            // one strobe on entry to ST_READ
            read_req_q <= (state_q == ST_ADDRESS) && ea_ready;
        end
    end

    // held instruction and read data
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            instr_hold <= in_instr;
        end
        if ((state_q == ST_READ) && read_done) begin
            read_data_q <= read_data;
        end
    end

    assign in_ready = (state_q == ST_IDLE);

    // string loads address through esi with no displacement
    assign ea_base = ctrl.addr_from_esi ? esi_value : rm_value;
    assign ea_disp = ctrl.addr_from_esi ? '0 : instr_hold.imm;

    assign read_req  = read_req_q;
    assign read_addr = ea;

    // --------------------------------------------------
    // execute hand-off
    // --------------------------------------------------
    always_comb begin
        case (ctrl.src_sel)
            SRC_REG:    src_value = rm_value;
            SRC_IMM:    src_value = instr_hold.imm;
            SRC_MEMORY: src_value = read_data_q;
            default:    src_value = '0;
        endcase
        if (ctrl.string_ignore) begin
            src_value = '0;
        end
    end

    assign exe_valid        = (state_q == ST_EXE);
    assign exe_op.cmd       = instr_hold.cmd;
    assign exe_op.dst_reg   = ctrl.dst_reg;
    assign exe_op.dst_value = reg_value;
    assign exe_op.src_value = src_value;
    assign exe_op.skip      = ctrl.string_ignore;

    // destination goes busy as the op leaves
    assign issue = exe_valid && ctrl.dst_writes;

endmodule

`default_nettype wire

// File: design/read_effective_address.sv
// Effective address unit.
// Registers base plus displacement; ea_ready strobes one cycle after
// start. The address holds until the next start.
// 32-bit flat addressing only, wraps on overflow.
`timescale 1ns/1ps
`default_nettype none

module read_effective_address (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  rd_pkg::word_t     base,
    input  rd_pkg::word_t     disp,
    output rd_pkg::mem_req_t  ea,
    output logic              ea_ready
);
    import rd_pkg::*;

    word_t addr_q;
    logic  ready_q;

    // address register, loaded on start only
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= base + disp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= start;
        end
    end

    assign ea.address = addr_q;
    assign ea_ready   = ready_q;

endmodule

`default_nettype wire

// File: design/read_regfile.sv
// Eight general registers with asynchronous read ports.
// Written only by the writeback port; all registers clear on reset.
`timescale 1ns/1ps
`default_nettype none

module read_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_valid,
    input  rd_pkg::reg_idx_t  wb_reg,
    input  rd_pkg::word_t     wb_value,
    input  rd_pkg::reg_idx_t  rm_idx,
    input  rd_pkg::reg_idx_t  reg_idx,
    output rd_pkg::word_t     rm_value,
    output rd_pkg::word_t     reg_value,
    output rd_pkg::word_t     ecx_value,
    output rd_pkg::word_t     esi_value
);
    import rd_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_reg] <= wb_value;
        end
    end

    assign rm_value  = regs[rm_idx];
    assign reg_value = regs[reg_idx];

    // fixed ports for string ops
    assign ecx_value = regs[REG_ECX];
    assign esi_value = regs[REG_ESI];

endmodule

`default_nettype wire

// File: design/read_mutex.sv
// Register busy scoreboard.
// A bit is set when an instruction that writes the register is issued to
// execute, and cleared by the matching writeback.
// Issue and writeback to the same register in one cycle leave it busy.
`timescale 1ns/1ps
`default_nettype none

module read_mutex (
    input  logic               clk,
    input  logic               rst_n,
    input  rd_pkg::reg_mask_t  req_mask,
    input  logic               issue,
    input  rd_pkg::reg_idx_t   issue_reg,
    input  logic               wb_valid,
    input  rd_pkg::reg_idx_t   wb_reg,
    output logic               lock_wait
);
    import rd_pkg::*;

    reg_mask_t busy_bit;
    reg_mask_t busy_next;

    always_comb begin
        busy_next = busy_bit;
        if (wb_valid) begin
            busy_next[wb_reg] = 1'b0;
        end
        // issue applied last so it wins
        if (issue) begin
            busy_next[issue_reg] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_bit <= '0;
        end else begin
            busy_bit <= busy_next;
        end
    end

    // wait while any requested register is still owed a writeback
    assign lock_wait = |(req_mask & busy_bit);

endmodule

`default_nettype wire

// File: design/read_commands.sv
// Command decode of the held instruction into read-stage control.
// Purely combinational; the result is only meaningful while an
// instruction is held by the stage.
// ecx_value is the live register value, so string_ignore is only
// trusted once ecx is free of pending writebacks.
`timescale 1ns/1ps
`default_nettype none

module read_commands (
    input  rd_pkg::rd_instr_t instr,
    input  rd_pkg::word_t     ecx_value,
    output rd_pkg::rd_ctrl_t  ctrl
);
    import rd_pkg::*;

    logic rep_count_zero;

    // a repeated string op with ecx zero does nothing
    assign rep_count_zero = instr.rep && (ecx_value == '0);

    always_comb begin
        ctrl = '0;
        ctrl.src_sel = SRC_REG;

        case (instr.cmd)
            // --------------------------------------------------
            // reg <- rm
            // --------------------------------------------------
            CMD_MOV_RR: begin
                ctrl.src_sel    = SRC_REG;
                ctrl.dst_reg    = instr.reg_field;
                ctrl.dst_writes = 1'b1;
                ctrl.req_mask   = reg_bit(instr.rm_field) | reg_bit(instr.reg_field);
            end

            // --------------------------------------------------
            // reg <- [rm + disp]
            // --------------------------------------------------
            CMD_LOAD: begin
                ctrl.src_sel    = SRC_MEMORY;
                ctrl.need_read  = 1'b1;
                ctrl.dst_reg    = instr.reg_field;
                ctrl.dst_writes = 1'b1;
                ctrl.req_mask   = reg_bit(instr.rm_field) | reg_bit(instr.reg_field);
            end

            // --------------------------------------------------
            // reg <- reg + imm
            // --------------------------------------------------
            CMD_ADD_IMM: begin
                ctrl.src_sel    = SRC_IMM;
                ctrl.dst_reg    = instr.reg_field;
                ctrl.dst_writes = 1'b1;
                ctrl.req_mask   = reg_bit(instr.reg_field);
            end

            // --------------------------------------------------
            // eax <- [esi], optionally repeated
            // --------------------------------------------------
            CMD_LODS: begin
                ctrl.src_sel       = SRC_MEMORY;
                ctrl.addr_from_esi = 1'b1;
                ctrl.dst_reg       = REG_EAX;
                ctrl.dst_writes    = 1'b1;
                ctrl.req_mask      = reg_bit(REG_ESI) | reg_bit(REG_EAX);
                // count only matters with a prefix
                if (instr.rep) begin
                    ctrl.req_mask = ctrl.req_mask | reg_bit(REG_ECX);
                end
                ctrl.string_ignore = rep_count_zero;
                ctrl.need_read     = !rep_count_zero;
            end

            default: begin
                // unknown command passes through with no effect
                ctrl.dst_writes = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/rd_pkg.sv
// Shared types of the read stage.
// Eight 32-bit general registers only; no segments, flags or 16-bit modes.
// Command codes use the 7-bit width of the full command space, with only
// four commands defined here.
`default_nettype none

package rd_pkg;

    // --------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------
    typedef logic [2:0]  reg_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  reg_mask_t;
    typedef logic [6:0]  cmd_t;

    // register order as in the x86 encoding
    localparam reg_idx_t REG_EAX = 3'd0;
    localparam reg_idx_t REG_ECX = 3'd1;
    localparam reg_idx_t REG_EDX = 3'd2;
    localparam reg_idx_t REG_EBX = 3'd3;
    localparam reg_idx_t REG_ESP = 3'd4;
    localparam reg_idx_t REG_EBP = 3'd5;
    localparam reg_idx_t REG_ESI = 3'd6;
    localparam reg_idx_t REG_EDI = 3'd7;

    localparam int NUM_REGS = 8;

    // command codes
    localparam cmd_t CMD_MOV_RR  = 7'd17;
    localparam cmd_t CMD_LOAD    = 7'd18;
    localparam cmd_t CMD_ADD_IMM = 7'd19;
    localparam cmd_t CMD_LODS    = 7'd20;

    typedef enum logic [1:0] {
        SRC_REG    = 2'd0,
        SRC_MEMORY = 2'd1,
        SRC_IMM    = 2'd2
    } src_sel_t;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOCK    = 3'd1,
        ST_ADDRESS = 3'd2,
        ST_READ    = 3'd3,
        ST_EXE     = 3'd4
    } rd_state_t;

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------
    typedef struct packed {
        cmd_t     cmd;
        reg_idx_t reg_field;
        reg_idx_t rm_field;
        logic     rep;
        word_t    imm;       // displacement or immediate
    } rd_instr_t;

    typedef struct packed {
        src_sel_t  src_sel;
        logic      need_read;
        logic      addr_from_esi;
        reg_idx_t  dst_reg;
        logic      dst_writes;
        reg_mask_t req_mask;
        logic      string_ignore;
    } rd_ctrl_t;

    typedef struct packed {
        cmd_t     cmd;
        reg_idx_t dst_reg;
        word_t    dst_value;
        word_t    src_value;
        logic     skip;
    } exe_op_t;

    typedef struct packed {
        word_t address;
    } mem_req_t;

    // one-hot mask bit of a register
    function automatic reg_mask_t reg_bit(reg_idx_t idx);
        reg_mask_t mask;
        mask = '0;
        mask[idx] = 1'b1;
        return mask;
    endfunction

endpackage

`default_nettype wire
